// File: hw/uopPkg.sv
package uopPkg;

	typedef logic [31:0] instrWord;   // Instruction or micro-op
	typedef logic [3:0]  regIndex;    // Register number
	typedef logic [15:0] regList;     // LDM/STM register list
	typedef logic [4:0]  regCount;    // Registers in a list, 0 to 16
	typedef logic [11:0] offsetImm;   // Load/store immediate offset
	typedef logic [3:0]  rzSelect;    // Bit 3 is RA1 initial mux and bits 2..0 steer Rz to WA3 RA2 RA1

	// Kinds of instruction seen in decode
	typedef enum logic [2:0] {
		clsPlain,
		clsRsr,           // Register-shifted-register data processing
		clsMulAcc,        // MLA and long accumulate
		clsBranchLink,
		clsLdStIndexed,   // Single load/store with base update
		clsBlock          // LDM/STM
	} instrClass;

	// Who drives the shared micro-op bus
	typedef enum logic [1:0] {
		ownNone,
		ownBlock,
		ownTwoStep
	} seqOwner;

	typedef enum logic [1:0] {
		blkIdle,
		blkWalk,        // One transfer per listed register
		blkWriteback
	} blockState;

	typedef enum logic {
		tsIdle,
		tsSecond
	} twoStepState;

	// Field positions in the instruction word
	localparam int condLsb = 28;   // Condition field [31:28]
	localparam int pBit    = 24;   // Pre/post index
	localparam int uBit    = 23;   // Up/down
	localparam int wBit    = 21;   // Writeback
	localparam int lBit    = 20;   // Load/store
	localparam int rnLsb   = 16;   // Rn [19:16]
	localparam int rdLsb   = 12;   // Rd [15:12]

	localparam regIndex rzReg = 4'd15;   // Temporary register number

	// Data processing opcodes
	localparam logic [3:0] opAdd = 4'b0100;
	localparam logic [3:0] opSub = 4'b0010;
	localparam logic [3:0] opMov = 4'b1101;

	localparam int wordBytes = 4;   // Bytes per transfer

endpackage

// File: hw/instrClassifier.sv
`timescale 1ns/1ps

module instrClassifier (
	input  uopPkg::instrWord  instr,
	output uopPkg::instrClass instClass
);

	logic isRsr;
	logic isMulAcc;
	logic isBl;
	logic isLdStIdx;
	logic isBlock;

	// Data processing with the shift amount in a register, BX excluded
	assign isRsr = (instr[27:25] == 3'b000) && !instr[7] && instr[4] &&
		(instr[27:6] != {8'b0001_0010, 12'hFFF, 2'b00});

	assign isMulAcc = (instr[27:24] == 4'b0000) && instr[21] &&
		(instr[7:4] == 4'b1001);   // A bit set on MUL/MULL encodings

	assign isBl = (instr[27:24] == 4'b1011);   // Link bit set

	// Post-indexed always writes Rn back and pre-indexed only with W
	assign isLdStIdx = (instr[27:26] == 2'b01) && !(instr[25] && instr[4]) &&
		(!instr[uopPkg::pBit] || instr[uopPkg::wBit]);

	assign isBlock = (instr[27:25] == 3'b100);

	// Priority follows the decode order of the pipeline
	always_comb begin
		if (isRsr) begin
			instClass = uopPkg::clsRsr;
		end else if (isMulAcc) begin
			instClass = uopPkg::clsMulAcc;
		end else if (isBl) begin
			instClass = uopPkg::clsBranchLink;
		end else if (isLdStIdx) begin
			instClass = uopPkg::clsLdStIndexed;
		end else if (isBlock) begin
			instClass = uopPkg::clsBlock;
		end else begin
			instClass = uopPkg::clsPlain;   // Goes straight through
		end
	end

endmodule

// File: hw/regListWalker.sv
`timescale 1ns/1ps

module regListWalker (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  uopPkg::instrWord instr,
	input  logic             first,
	output uopPkg::regIndex  nextReg,
	output uopPkg::regCount  remaining,
	output uopPkg::offsetImm startOffset,
	output logic             addUp
);

	uopPkg::regList listNow;    // Registers not yet transferred
	uopPkg::regList curList;    // List seen this step
	uopPkg::regList listNext;

	assign curList   = first ? instr[15:0] : listNow;   // Whole list on the first step
	assign listNext  = curList & (curList - 16'd1);     // Clear lowest set bit
	assign remaining = uopPkg::regCount'($countones(curList));

	// Lowest listed register goes first
	always_comb begin
		nextReg = '0;
		for (int i = 15; i >= 0; i--) begin
			if (curList[i])
				nextReg = uopPkg::regIndex'(i);
		end
	end

	// Start address relative to Rn from the P and U bits
	always_comb begin
		case ({instr[uopPkg::pBit], instr[uopPkg::uBit]})
			2'b01: begin   // Increment after
				startOffset = '0;
				addUp       = 1'b1;
			end
			2'b11: begin   // Increment before
				startOffset = uopPkg::offsetImm'(uopPkg::wordBytes);
				addUp       = 1'b1;
			end
			2'b00: begin   // Decrement after
				startOffset = uopPkg::offsetImm'((remaining - 5'd1) * uopPkg::wordBytes);
				addUp       = 1'b0;
			end
			default: begin   // Decrement before
				startOffset = uopPkg::offsetImm'(remaining * uopPkg::wordBytes);
				addUp       = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			listNow <= '0;
		else if (!stall)
			listNow <= listNext;   // One register consumed per step
	end

endmodule

// File: hw/blockTransferSeq.sv
`timescale 1ns/1ps

module blockTransferSeq (
	input  logic             clk,
	input  logic             reset,
	input  logic             stall,
	input  uopPkg::instrWord instr,
	input  logic             start,
	output logic             busy,
	output uopPkg::instrWord uop,
	output logic             uopValid,
	output logic             uopStall,
	output logic             holdFlags,
	output logic             ldmStmForward,
	output uopPkg::rzSelect  rzSel
);

	uopPkg::blockState state, nextState;
	uopPkg::regIndex   nextReg;
	uopPkg::regCount   remaining;
	uopPkg::offsetImm  startOffset;
	logic              addUp;
	logic [3:0]        cond;
	uopPkg::regIndex   rn;

	assign cond = instr[uopPkg::condLsb +: 4];
	assign rn   = instr[uopPkg::rnLsb +: 4];
	assign busy = (state != uopPkg::blkIdle);

	// Counts the held list again while idle and during writeback
	regListWalker walker (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.instr       (instr),
		.first       (state != uopPkg::blkWalk),
		.nextReg     (nextReg),
		.remaining   (remaining),
		.startOffset (startOffset),
		.addUp       (addUp)
	);

	always_ff @(posedge clk) begin
		if (reset)
			state <= uopPkg::blkIdle;
		else if (!stall)
			state <= nextState;
	end

	always_comb begin
		nextState     = state;
		uop           = instr;   // Pass through unless a step is active
		uopValid      = 1'b0;
		uopStall      = 1'b0;
		holdFlags     = 1'b0;
		ldmStmForward = 1'b0;
		rzSel         = '0;
		case (state)
			uopPkg::blkIdle: begin
				if (start) begin
					uopValid  = 1'b1;
					uopStall  = 1'b1;
					holdFlags = 1'b1;
					// Pre-indexed LDR/STR from Rn at the start offset
					uop = {cond, 3'b010, 1'b1, addUp, 1'b0, 1'b0, instr[uopPkg::lBit],
						rn, nextReg, startOffset};
					nextState = uopPkg::blkWalk;
				end
			end
			uopPkg::blkWalk: begin
				uopValid  = 1'b1;
				holdFlags = 1'b1;
				if (remaining == '0) begin   // List had one register or none
					uop       = {4'b1111, 3'b001, uopPkg::opAdd, 1'b0, 20'b0};   // Never executes
					nextState = uopPkg::blkIdle;
				end else begin
					// Next word above the address held in Rz
					uop = {cond, 3'b010, 1'b1, 1'b1, 1'b0, 1'b0, instr[uopPkg::lBit],
						uopPkg::rzReg, nextReg, uopPkg::offsetImm'(uopPkg::wordBytes)};
					ldmStmForward = 1'b1;
					rzSel         = 4'b0001;   // Rz on RA1
					if (remaining != 5'd1) begin
						uopStall = 1'b1;   // More registers to go
					end else if (instr[uopPkg::wBit]) begin
						uopStall  = 1'b1;
						nextState = uopPkg::blkWriteback;
					end else begin
						nextState = uopPkg::blkIdle;
					end
				end
			end
			uopPkg::blkWriteback: begin
				uopValid  = 1'b1;
				holdFlags = 1'b1;
				// Rn = Rn +/- N rotated right by 30
				uop = {cond, 3'b001, instr[uopPkg::uBit] ? uopPkg::opAdd : uopPkg::opSub,
					1'b0, rn, rn, 4'b1111, 3'b000, remaining};
				nextState = uopPkg::blkIdle;
			end
			default: nextState = uopPkg::blkIdle;
		endcase
	end

endmodule

// File: hw/twoStepSeq.sv
`timescale 1ns/1ps

module twoStepSeq (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  uopPkg::instrWord  instr,
	input  uopPkg::instrClass instClass,
	input  logic              start,
	output logic              busy,
	output uopPkg::instrWord  uop,
	output logic              uopValid,
	output logic              uopStall,
	output logic              holdFlags,
	output logic              keepV,
	output logic              rsrSecond,
	output uopPkg::rzSelect   rzSel
);

	uopPkg::twoStepState state, nextState;
	logic [3:0]          cond;
	uopPkg::regIndex     rn;
	uopPkg::regIndex     rd;
	logic [3:0]          idxOp;        // ADD or SUB from the U bit
	uopPkg::instrWord    lsAccess;     // Plain access at Rn
	uopPkg::instrWord    baseUpdate;   // Rn = Rn +/- offset

	assign cond  = instr[uopPkg::condLsb +: 4];
	assign rn    = instr[uopPkg::rnLsb +: 4];
	assign rd    = instr[uopPkg::rdLsb +: 4];
	assign idxOp = instr[uopPkg::uBit] ? uopPkg::opAdd : uopPkg::opSub;
	assign busy  = (state == uopPkg::tsSecond);

	assign lsAccess = {cond, 3'b010, 1'b1, instr[uopPkg::uBit], instr[22], 1'b0,
		instr[uopPkg::lBit], rn, rd, 12'b0};
	// I bit flips between load/store and data processing encodings
	assign baseUpdate = {cond, 2'b00, !instr[25], idxOp, 1'b0, rn, rn, instr[11:0]};

	always_ff @(posedge clk) begin
		if (reset)
			state <= uopPkg::tsIdle;
		else if (!stall)
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		uop       = instr;
		uopValid  = 1'b0;
		uopStall  = 1'b0;
		holdFlags = 1'b0;
		keepV     = 1'b0;
		rsrSecond = 1'b0;
		rzSel     = '0;
		if (start || busy) begin
			uopValid  = 1'b1;
			uopStall  = !busy;   // Fetch held in the first step only
			nextState = busy ? uopPkg::tsIdle : uopPkg::tsSecond;
			case (instClass)
				uopPkg::clsRsr: begin
					if (!busy) begin
						// MOV Rz, Rm shifted by Rs
						uop = {instr[31:25], uopPkg::opMov, 1'b0, 4'b0000, uopPkg::rzReg, instr[11:0]};
						holdFlags = 1'b1;
						rzSel     = 4'b1100;   // Rz written through WA3
					end else begin
						uop       = {instr[31:12], 8'b0, uopPkg::rzReg};   // Rz as unshifted Rm
						rsrSecond = 1'b1;
						rzSel     = 4'b0010;
					end
				end
				uopPkg::clsMulAcc: begin
					if (!busy) begin
						// MUL Rz, Rm, Rs with accumulate cleared
						uop = {instr[31:24], 1'b0, instr[22], 2'b00, uopPkg::rzReg, 4'b0000, instr[11:0]};
						keepV = 1'b1;
						rzSel = 4'b1100;
					end else begin
						// Rd = Rz + accumulator register
						uop = {cond, 3'b000, uopPkg::opAdd, instr[uopPkg::lBit], uopPkg::rzReg,
							instr[19:16], 8'b0, instr[15:12]};
						rzSel = 4'b0001;
					end
				end
				uopPkg::clsBranchLink: begin
					if (!busy)
						uop = {cond, 3'b001, uopPkg::opSub, 1'b0, 4'hF, 4'hE, 4'h0, 8'd4};   // LR = PC - 4
					else
						uop = {instr[31:25], 1'b0, instr[23:0]};   // Branch without link
				end
				uopPkg::clsLdStIndexed: begin
					holdFlags = 1'b1;
					// Post-indexed accesses first and pre-indexed updates Rn first
					uop = (instr[uopPkg::pBit] == busy) ? lsAccess : baseUpdate;
				end
				default: begin   // Not a two-step kind
					uopValid  = 1'b0;
					uopStall  = 1'b0;
					nextState = uopPkg::tsIdle;
				end
			endcase
		end
	end

endmodule

// File: hw/uopArbiter.sv
`timescale 1ns/1ps

module uopArbiter (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  uopPkg::instrClass instClass,
	input  uopPkg::instrWord  instr,
	input  logic              blockBusy,
	input  logic              twoStepBusy,
	output logic              blockStart,
	output logic              twoStepStart,
	input  uopPkg::instrWord  blkUop,
	input  logic              blkUopValid, blkUopStall, blkHoldFlags, blkLdmStmForward,
	input  uopPkg::rzSelect   blkRzSel,
	input  uopPkg::instrWord  tsUop,
	input  logic              tsUopValid, tsUopStall, tsHoldFlags, tsKeepV, tsRsrSecond,
	input  uopPkg::rzSelect   tsRzSel,
	output uopPkg::instrWord  uop,
	output logic              uopValid, uopStall, holdFlags, rsrSecond, keepV, ldmStmForward,
	output uopPkg::rzSelect   rzSel
);

	uopPkg::seqOwner ownerReg;   // Registered bus owner
	uopPkg::seqOwner curOwner;   // Owner after a finished sequence is released
	uopPkg::seqOwner sel;        // Source of this cycle's outputs
	logic            ownerDone;

	assign ownerDone = (ownerReg == uopPkg::ownBlock && !blockBusy) ||
		(ownerReg == uopPkg::ownTwoStep && !twoStepBusy);
	assign curOwner = ownerDone ? uopPkg::ownNone : ownerReg;   // Free once busy falls

	assign blockStart   = (curOwner == uopPkg::ownNone) && (instClass == uopPkg::clsBlock);
	assign twoStepStart = (curOwner == uopPkg::ownNone) && (instClass inside
		{uopPkg::clsRsr, uopPkg::clsMulAcc, uopPkg::clsBranchLink, uopPkg::clsLdStIndexed});

	// A starting sequencer owns the bus from its first step
	always_comb begin
		sel = curOwner;
		if (blockStart)
			sel = uopPkg::ownBlock;
		else if (twoStepStart)
			sel = uopPkg::ownTwoStep;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ownerReg <= uopPkg::ownNone;
		else if (!stall)
			ownerReg <= sel;   // Set on grant and cleared on release
	end

	always_comb begin
		uop           = instr;   // Plain instruction goes straight through
		uopValid      = 1'b0;
		uopStall      = 1'b0;
		holdFlags     = 1'b0;
		rsrSecond     = 1'b0;
		keepV         = 1'b0;
		ldmStmForward = 1'b0;
		rzSel         = '0;
		case (sel)
			uopPkg::ownBlock: begin
				uop           = blkUop;
				uopValid      = blkUopValid;
				uopStall      = blkUopStall;
				holdFlags     = blkHoldFlags;
				ldmStmForward = blkLdmStmForward;
				rzSel         = blkRzSel;
			end
			uopPkg::ownTwoStep: begin
				uop       = tsUop;
				uopValid  = tsUopValid;
				uopStall  = tsUopStall;
				holdFlags = tsHoldFlags;
				rsrSecond = tsRsrSecond;
				keepV     = tsKeepV;
				rzSel     = tsRzSel;
			end
			default: ;
		endcase
	end

endmodule

// File: hw/microOpSequencer.sv
`timescale 1ns/1ps

module microOpSequencer (
	input  logic             clk,
	input  logic             reset,
	input  uopPkg::instrWord instr,
	input  logic             stall,
	output logic             uopValid,
	output uopPkg::instrWord uop,
	output logic             holdFlags,
	output logic             uopStall,
	output uopPkg::rzSelect  rzSel,
	output logic             rsrSecond,
	output logic             keepV,
	output logic             ldmStmForward
);

	uopPkg::instrClass instClass;
	logic              blockStart, twoStepStart;
	logic              blockBusy, twoStepBusy;
	uopPkg::instrWord  blkUop, tsUop;
	logic              blkUopValid, blkUopStall, blkHoldFlags, blkLdmStmForward;
	logic              tsUopValid, tsUopStall, tsHoldFlags, tsKeepV, tsRsrSecond;
	uopPkg::rzSelect   blkRzSel, tsRzSel;

	instrClassifier classifier (
		.instr     (instr),
		.instClass (instClass)
	);

	blockTransferSeq blockSeq (
		.clk           (clk),
		.reset         (reset),
		.stall         (stall),
		.instr         (instr),
		.start         (blockStart),
		.busy          (blockBusy),
		.uop           (blkUop),
		.uopValid      (blkUopValid),
		.uopStall      (blkUopStall),
		.holdFlags     (blkHoldFlags),
		.ldmStmForward (blkLdmStmForward),
		.rzSel         (blkRzSel)
	);

	twoStepSeq twoStep (
		.clk       (clk),
		.reset     (reset),
		.stall     (stall),
		.instr     (instr),
		.instClass (instClass),
		.start     (twoStepStart),
		.busy      (twoStepBusy),
		.uop       (tsUop),
		.uopValid  (tsUopValid),
		.uopStall  (tsUopStall),
		.holdFlags (tsHoldFlags),
		.keepV     (tsKeepV),
		.rsrSecond (tsRsrSecond),
		.rzSel     (tsRzSel)
	);

	uopArbiter arbiter (
		.clk              (clk),
		.reset            (reset),
		.stall            (stall),
		.instClass        (instClass),
		.instr            (instr),
		.blockBusy        (blockBusy),
		.twoStepBusy      (twoStepBusy),
		.blockStart       (blockStart),
		.twoStepStart     (twoStepStart),
		.blkUop           (blkUop),
		.blkUopValid      (blkUopValid),
		.blkUopStall      (blkUopStall),
		.blkHoldFlags     (blkHoldFlags),
		.blkLdmStmForward (blkLdmStmForward),
		.blkRzSel         (blkRzSel),
		.tsUop            (tsUop),
		.tsUopValid       (tsUopValid),
		.tsUopStall       (tsUopStall),
		.tsHoldFlags      (tsHoldFlags),
		.tsKeepV          (tsKeepV),
		.tsRsrSecond      (tsRsrSecond),
		.tsRzSel          (tsRzSel),
		.uop              (uop),
		.uopValid         (uopValid),
		.uopStall         (uopStall),
		.holdFlags        (holdFlags),
		.rsrSecond        (rsrSecond),
		.keepV            (keepV),
		.ldmStmForward    (ldmStmForward),
		.rzSel            (rzSel)
	);

endmodule

// File: dv/microOpSequencer_sva.sv
`timescale 1ns/1ps

module microOpSequencer_sva (
	input logic             clk,
	input logic             reset,
	input logic             stall,
	input logic             uopValid,
	input uopPkg::instrWord uop,
	input logic             holdFlags,
	input logic             uopStall,
	input uopPkg::rzSelect  rzSel,
	input logic             rsrSecond,
	input logic             keepV,
	input logic             ldmStmForward
);

	// Fetch is held only while a micro-op replaces the instruction
	stallHasValid: assert property (@(posedge clk) disable iff (reset) uopStall |-> uopValid)
		else $error("uopStall high without uopValid");

	// Pipeline stall freezes the micro-op
	uopFrozen: assert property (@(posedge clk) disable iff (reset) stall |=> $stable(uop))
		else $error("uop changed during a pipeline stall");

	ctrlFrozen: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable({uopValid, uopStall, holdFlags, rzSel, rsrSecond, keepV, ldmStmForward}))
		else $error("Control outputs changed during a pipeline stall");

endmodule

bind microOpSequencer microOpSequencer_sva sva (
	.clk           (clk),
	.reset         (reset),
	.stall         (stall),
	.uopValid      (uopValid),
	.uop           (uop),
	.holdFlags     (holdFlags),
	.uopStall      (uopStall),
	.rzSel         (rzSel),
	.rsrSecond     (rsrSecond),
	.keepV         (keepV),
	.ldmStmForward (ldmStmForward)
);

// File: dv/microOpSequencerTb.sv
`timescale 1ns/1ps

module microOpSequencerTb;

	localparam int clkPeriod = 100;   // ns
	localparam int numInstr  = 400;
	localparam int maxCycles = 20;    // Per instruction with stalls included
	localparam uopPkg::instrWord plainWord = 32'hE3A0_0000;   // MOV r0, #0

	logic             clk;
	logic             reset;
	uopPkg::instrWord instr;
	logic             stall;
	logic             uopValid;
	uopPkg::instrWord uop;
	logic             holdFlags;
	logic             uopStall;
	uopPkg::rzSelect  rzSel;
	logic             rsrSecond;
	logic             keepV;
	logic             ldmStmForward;

	logic [31:0]      lcgState;
	uopPkg::instrWord expUop[$];    // Expected micro-op per unstalled step
	logic [3:0]       expFlags[$];  // {holdFlags, keepV, rsrSecond, ldmStmForward} per step
	uopPkg::rzSelect  expRz[$];     // Rz steering per step
	uopPkg::regIndex  expRegs[$];   // Ascending transfer registers of a block
	logic             expValid;
	logic             stallOn;      // Random pipeline stalls enabled

	microOpSequencer UUT (
		.clk           (clk),
		.reset         (reset),
		.instr         (instr),
		.stall         (stall),
		.uopValid      (uopValid),
		.uop           (uop),
		.holdFlags     (holdFlags),
		.uopStall      (uopStall),
		.rzSel         (rzSel),
		.rsrSecond     (rsrSecond),
		.keepV         (keepV),
		.ldmStmForward (ldmStmForward)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [15:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState[31:16];   // Upper half, low bits have short periods
	endfunction

	function automatic logic nextStall();
		logic [15:0] r;
		r = nextRand();
		return stallOn && (r[1:0] == 2'b00);   // About one cycle in four
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkWord(input uopPkg::instrWord got, input uopPkg::instrWord exp,
		input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
	endtask

	task automatic checkReg(input uopPkg::regIndex got, input uopPkg::regIndex exp,
		input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s got r%0d expected r%0d", $time, what, got, exp));
	endtask

	task automatic checkCount(input uopPkg::regCount got, input uopPkg::regCount exp,
		input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp));
	endtask

	task automatic checkRzSel(input uopPkg::rzSelect got, input uopPkg::rzSelect exp,
		input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
			failRun($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
	endtask

	// One expected step with its control outputs
	task automatic pushStep(input uopPkg::instrWord w, input logic [3:0] flags,
		input uopPkg::rzSelect rz);
		expUop.push_back(w);
		expFlags.push_back(flags);   // {holdFlags, keepV, rsrSecond, ldmStmForward}
		expRz.push_back(rz);         // {RA1 mux, WA3, RA2, RA1}
	endtask

	// Random instruction of a kept class plus its expected micro-op stream
	task automatic pickInstr(output uopPkg::instrWord iw);
		logic [31:0]      r;
		logic [31:0]      r2;
		logic [3:0]       cond;
		logic [3:0]       kind;
		uopPkg::instrWord w;
		uopPkg::instrWord w2;
		uopPkg::regList   list;
		int               n;
		int               ofs;
		r    = {nextRand(), nextRand()};
		r2   = {nextRand(), nextRand()};
		kind = r2[31:28];
		cond = (r[31:28] == 4'hF) ? 4'hE : r[31:28];   // 1111 left to never-executing steps
		expUop.delete();
		expFlags.delete();
		expRz.delete();
		expRegs.delete();
		expValid = 1'b1;
		if (kind < 4'd3) begin   // Data processing with immediate, passes through
			iw = {cond, 3'b001, r[24:0]};
			expValid = 1'b0;
			pushStep(iw, 4'b0000, 4'b0000);
		end else if (kind < 4'd5) begin   // RSR
			iw = {cond, 3'b000, r[24:8], 1'b0, r[6:5], 1'b1, r[3:0]};
			if (iw[24:23] == 2'b10)
				iw[20] = 1'b1;   // Compares always set flags
			w = iw;
			w[24:21] = uopPkg::opMov;
			w[20]    = 1'b0;
			w[19:16] = 4'h0;
			w[15:12] = uopPkg::rzReg;   // Shifted operand lands in Rz
			pushStep(w, 4'b1000, 4'b1100);   // Flags held, Rz written
			w = iw;
			w[11:4] = 8'h00;
			w[3:0]  = uopPkg::rzReg;   // Same operation on plain Rz
			pushStep(w, 4'b0010, 4'b0010);   // Rz read as Rm
		end else if (kind < 4'd7) begin   // MLA and long accumulate forms
			iw = {cond, 4'b0000, r[23:22], 1'b1, r[20], r[19:8], 4'b1001, r[3:0]};
			w = iw;
			w[23]    = 1'b0;
			w[21]    = 1'b0;   // Accumulate off
			w[20]    = 1'b0;
			w[19:16] = uopPkg::rzReg;
			w[15:12] = 4'h0;
			pushStep(w, 4'b0100, 4'b1100);   // V kept, Rz written
			w = '0;
			w[31:28] = cond;
			w[24:21] = uopPkg::opAdd;
			w[20]    = iw[20];
			w[19:16] = uopPkg::rzReg;
			w[15:12] = iw[19:16];   // Product plus accumulator into Rd
			w[3:0]   = iw[15:12];
			pushStep(w, 4'b0000, 4'b0001);   // Rz read as Rn
		end else if (kind < 4'd9) begin   // BL
			iw = {cond, 4'b1011, r[23:0]};
			w = '0;
			w[31:28] = cond;
			w[25]    = 1'b1;
			w[24:21] = uopPkg::opSub;
			w[19:16] = 4'hF;   // LR = PC - 4
			w[15:12] = 4'hE;
			w[7:0]   = 8'd4;
			pushStep(w, 4'b0000, 4'b0000);
			w = iw;
			w[24] = 1'b0;   // Plain branch
			pushStep(w, 4'b0000, 4'b0000);
		end else if (kind < 4'd12) begin   // Indexed load/store
			iw = {cond, 2'b01, r[25:0]};
			if (iw[uopPkg::pBit])
				iw[uopPkg::wBit] = 1'b1;
			if (iw[25])
				iw[4] = 1'b0;   // Register offset with immediate shift
			w = iw;
			w[25]   = 1'b0;
			w[24]   = 1'b1;
			w[21]   = 1'b0;
			w[11:0] = 12'h000;   // Access at Rn
			w2 = '0;
			w2[31:28] = cond;
			w2[25]    = ~iw[25];
			w2[24:21] = iw[uopPkg::uBit] ? uopPkg::opAdd : uopPkg::opSub;
			w2[19:16] = iw[19:16];
			w2[15:12] = iw[19:16];
			w2[11:0]  = iw[11:0];
			if (iw[uopPkg::pBit]) begin
				pushStep(w2, 4'b1000, 4'b0000);   // Pre-indexed updates the base first
				pushStep(w, 4'b1000, 4'b0000);
			end else begin
				pushStep(w, 4'b1000, 4'b0000);
				pushStep(w2, 4'b1000, 4'b0000);
			end
		end else begin   // LDM/STM
			case (r2[1:0])
				2'b00:   list = 16'd1 << r2[7:4];
				2'b01:   list = r2[23:8] & r[15:0];
				default: list = r2[23:8];
			endcase
			if (list == 16'h0000)
				list = 16'd1 << r2[7:4];   // Empty list is unpredictable
			iw = {cond, 3'b100, r[24:16], list};
			for (int i = 0; i < 16; i++) begin
				if (list[i])
					expRegs.push_back(uopPkg::regIndex'(i));
			end
			n = expRegs.size();
			if (iw[uopPkg::uBit])
				ofs = iw[uopPkg::pBit] ? uopPkg::wordBytes : 0;
			else
				ofs = iw[uopPkg::pBit] ? uopPkg::wordBytes * n : uopPkg::wordBytes * (n - 1);
			w = iw;
			w[27:21] = {3'b010, 1'b1, iw[uopPkg::uBit], 2'b00};
			w[15:12] = expRegs[0];
			w[11:0]  = 12'(ofs);
			pushStep(w, 4'b1000, 4'b0000);
			w[23]    = 1'b1;
			w[19:16] = uopPkg::rzReg;
			w[11:0]  = 12'(uopPkg::wordBytes);
			for (int k = 1; k < n; k++) begin
				w[15:12] = expRegs[k];
				pushStep(w, 4'b1001, 4'b0001);   // Rz forwarded as base on RA1
			end
			if (n == 1)
				pushStep({4'hF, 3'b001, uopPkg::opAdd, 21'h0}, 4'b1000, 4'b0000);
			else if (iw[uopPkg::wBit])
				pushStep({cond, 3'b001, iw[uopPkg::uBit] ? uopPkg::opAdd : uopPkg::opSub,
					1'b0, iw[19:16], iw[19:16], 4'hF, 8'(n)},   // Imm N ror 30 is 4N
					4'b1000, 4'b0000);
		end
	endtask

	// Present one instruction and follow it until fetch is released
	task automatic runSequence(input uopPkg::instrWord iw);
		int   step;
		logic done;
		step = 0;
		done = 1'b0;
		@(posedge clk);
		instr <= iw;
		stall <= nextStall();
		while (!done) begin
			@(negedge clk);
			if (step >= expUop.size())   // Fetch still held after the last expected step
				checkCount(uopPkg::regCount'(step + 1), uopPkg::regCount'(expUop.size()),
					"sequence length");
			checkWord(uop, expUop[step], "uop");
			checkBit(uopValid, expValid, "uopValid");
			checkBit(holdFlags, expFlags[step][3], "holdFlags");
			checkBit(keepV, expFlags[step][2], "keepV");
			checkBit(rsrSecond, expFlags[step][1], "rsrSecond");
			checkBit(ldmStmForward, expFlags[step][0], "ldmStmForward");
			checkRzSel(rzSel, expRz[step], "rzSel");
			if (step < expRegs.size())
				checkReg(uop[uopPkg::rdLsb +: 4], expRegs[step], "transfer register");
			if (!stall) begin   // Step taken only when the pipeline moves
				step++;
				done = !uopStall;
			end
			if (!done) begin
				@(posedge clk);
				stall <= nextStall();
			end
		end
		checkCount(uopPkg::regCount'(step), uopPkg::regCount'(expUop.size()), "sequence length");
	endtask

	initial begin
		#(numInstr * maxCycles * clkPeriod);
		failRun("Watchdog timeout: the instruction stream did not complete in time");
	end

	initial begin
		uopPkg::instrWord iw;
		lcgState = 32'd35308;
		stallOn  = 1'b0;
		reset   <= 1'b1;
		stall   <= 1'b0;
		instr   <= plainWord;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkWord(uop, plainWord, "uop after reset");   // Plain word straight through
		checkBit(uopValid, 1'b0, "uopValid after reset");
		checkBit(uopStall, 1'b0, "uopStall after reset");
		for (int i = 0; i < numInstr; i++) begin
			stallOn = (i >= 40);   // Clean timing first, then random stalls
			pickInstr(iw);
			runSequence(iw);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: all.f
hw/uopPkg.sv
hw/instrClassifier.sv
hw/regListWalker.sv
hw/blockTransferSeq.sv
hw/twoStepSeq.sv
hw/uopArbiter.sv
hw/microOpSequencer.sv
dv/microOpSequencer_sva.sv
dv/microOpSequencerTb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := microOpSequencerTb
FILELIST  := all.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hw/*.sv dv/*.sv)
FAILMSG   := FAIL: see errors above
PASSMSG   := PASS: all tests

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
